//--- verilog/des_pkg.sv
package des_pkg;

    // datapath widths
    localparam int BLOCK_W    = 64;
    localparam int HALF_W     = 32;
    localparam int SUBKEY_W   = 48;
    localparam int CD_W       = 28;
    localparam int SBOX_IN_W  = 6;
    localparam int SBOX_OUT_W = 4;

    localparam int ROUNDS       = 16;
    // input register + 16 rounds + output register
    localparam int PIPE_LATENCY = ROUNDS + 2;

    typedef logic [BLOCK_W-1:0]  block_t;
    typedef logic [HALF_W-1:0]   half_t;
    typedef logic [SUBKEY_W-1:0] subkey_t;
    typedef logic [CD_W-1:0]     cd_t;

    // feistel state carried from stage to stage
    typedef struct packed {
        half_t left;
        half_t right;
    } half_pair_t;

    typedef subkey_t subkey_array_t [1:ROUNDS];

    // all tables use DES numbering, bit 1 is the msb

    localparam int IP_TABLE [BLOCK_W] = '{
        58, 50, 42, 34, 26, 18, 10,  2,
        60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6,
        64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1,
        59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5,
        63, 55, 47, 39, 31, 23, 15,  7
    };

    // inverse of IP
    localparam int FP_TABLE [BLOCK_W] = '{
        40,  8, 48, 16, 56, 24, 64, 32,
        39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30,
        37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28,
        35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26,
        33,  1, 41,  9, 49, 17, 57, 25
    };

    // expansion of the right half to 48 bits
    localparam int E_TABLE [SUBKEY_W] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    localparam int P_TABLE [HALF_W] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    // drops the parity bits of the key
    localparam int PC1_TABLE [2*CD_W] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TABLE [SUBKEY_W] = '{
        14, 17, 11, 24,  1,  5,
         3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8,
        16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    // left rotation per round for C and D
    localparam int SHIFT_TABLE [ROUNDS] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

    // indexed by row * 16 + column
    localparam logic [SBOX_OUT_W-1:0] SBOX_TABLE [SUBKEY_W/SBOX_IN_W][1 << SBOX_IN_W] = '{
        // s1
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        // s2
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        // s3
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        // s4
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        // s5
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        // s6
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        // s7
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        // s8
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

endpackage

//--- verilog/des_key_schedule.sv
module des_key_schedule
    import des_pkg::*;
(
    input  block_t        key,
    output subkey_array_t subkeys
);

    logic [2*CD_W-1:0] pc1_out;

    // c/d after each round's rotation, index 0 is straight after PC-1
    cd_t c [0:ROUNDS];
    cd_t d [0:ROUNDS];

    // PC-1 picks 56 of the 64 key bits
    always_comb begin
        for (int i = 0; i < 2*CD_W; i++) begin
            pc1_out[2*CD_W-1-i] = key[BLOCK_W-PC1_TABLE[i]];
        end
    end

    assign c[0] = pc1_out[2*CD_W-1 -: CD_W];
    assign d[0] = pc1_out[CD_W-1:0];

    for (genvar r = 1; r <= ROUNDS; r++) begin : g_round_key
        logic [2*CD_W-1:0] cd;
        subkey_t           pc2_out;

        // rotations accumulate from one round to the next
        assign c[r] = (c[r-1] << SHIFT_TABLE[r-1]) | (c[r-1] >> (CD_W-SHIFT_TABLE[r-1]));
        assign d[r] = (d[r-1] << SHIFT_TABLE[r-1]) | (d[r-1] >> (CD_W-SHIFT_TABLE[r-1]));
        assign cd = {c[r], d[r]};

        always_comb begin
            for (int i = 0; i < SUBKEY_W; i++) begin
                pc2_out[SUBKEY_W-1-i] = cd[2*CD_W-PC2_TABLE[i]];
            end
        end

        assign subkeys[r] = pc2_out;
    end

endmodule

//--- verilog/des_feistel.sv
module des_feistel
    import des_pkg::*;
(
    input  half_t   right,
    input  subkey_t subkey,
    output half_t   f_out
);

    subkey_t expanded;
    subkey_t mixed;
    half_t   sbox_out;

    always_comb begin
        for (int i = 0; i < SUBKEY_W; i++) begin
            expanded[SUBKEY_W-1-i] = right[HALF_W-E_TABLE[i]];
        end
    end

    assign mixed = expanded ^ subkey;

    // s1 takes the top six bits of the mixed value
    always_comb begin
        logic [SBOX_IN_W-1:0] group;
        for (int s = 0; s < SUBKEY_W/SBOX_IN_W; s++) begin
            group = mixed[SUBKEY_W-1-SBOX_IN_W*s -: SBOX_IN_W];
            // outer bits give the row, inner four the column
            sbox_out[HALF_W-1-SBOX_OUT_W*s -: SBOX_OUT_W] =
                SBOX_TABLE[s][{group[SBOX_IN_W-1], group[0], group[SBOX_IN_W-2:1]}];
        end
    end

    always_comb begin
        for (int i = 0; i < HALF_W; i++) begin
            f_out[HALF_W-1-i] = sbox_out[HALF_W-P_TABLE[i]];
        end
    end

endmodule

//--- verilog/des_round.sv
module des_round
    import des_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       in_valid,
    input  half_pair_t in_state,
    input  subkey_t    subkey,
    output logic       out_valid,
    output half_pair_t out_state
);

    half_t f_out;

    des_feistel u_feistel (
        .right  (in_state.right),
        .subkey (subkey),
        .f_out  (f_out)
    );

    // one feistel step per cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_state <= '0;
        end else begin
            out_valid       <= in_valid;
            out_state.left  <= in_state.right;
            out_state.right <= in_state.left ^ f_out;
        end
    end

    // the valid flag moves exactly one stage per clock
    valid_follows_input: assert property (
        @(posedge clock) !rst && !$past(rst) |-> out_valid == $past(in_valid)
    );

endmodule

//--- verilog/des_input_stage.sv
module des_input_stage
    import des_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       iv,
    input  block_t     plaintext,
    output logic       out_valid,
    output half_pair_t out_state
);

    block_t ip_out;

    always_comb begin
        for (int i = 0; i < BLOCK_W; i++) begin
            ip_out[BLOCK_W-1-i] = plaintext[BLOCK_W-IP_TABLE[i]];
        end
    end

    // L0 is the upper half of the permuted block
    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_state <= '0;
        end else begin
            out_valid       <= iv;
            out_state.left  <= ip_out[BLOCK_W-1 -: HALF_W];
            out_state.right <= ip_out[HALF_W-1:0];
        end
    end

    iv_known: assert property (@(posedge clock) disable iff (rst) !$isunknown(iv));

endmodule

//--- verilog/des_output_stage.sv
module des_output_stage
    import des_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       in_valid,
    input  half_pair_t in_state,
    output block_t     ciphertext,
    output logic       ov
);

    block_t preoutput;
    block_t fp_out;

    // halves swap back after round 16
    assign preoutput = {in_state.right, in_state.left};

    always_comb begin
        for (int i = 0; i < BLOCK_W; i++) begin
            fp_out[BLOCK_W-1-i] = preoutput[BLOCK_W-FP_TABLE[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ov         <= 1'b0;
            ciphertext <= '0;
        end else begin
            ov         <= in_valid;
            ciphertext <= fp_out;
        end
    end

    ciphertext_known: assert property (
        @(posedge clock) disable iff (rst) ov |-> !$isunknown(ciphertext)
    );

endmodule

//--- verilog/des.sv
module des
    import des_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  block_t key,
    input  block_t plaintext,
    input  logic   iv,
    output block_t ciphertext,
    output logic   ov
);

    // key is held static while blocks are in flight
    subkey_array_t subkeys;

    // state[0] leaves the input stage, state[ROUNDS] enters the output stage
    half_pair_t        state [0:ROUNDS];
    logic [ROUNDS:0]   v;

    des_key_schedule u_key_schedule (
        .key     (key),
        .subkeys (subkeys)
    );

    des_input_stage u_input_stage (
        .clock     (clock),
        .rst       (rst),
        .iv        (iv),
        .plaintext (plaintext),
        .out_valid (v[0]),
        .out_state (state[0])
    );

    for (genvar i = 1; i <= ROUNDS; i++) begin : g_round
        des_round u_round (
            .clock     (clock),
            .rst       (rst),
            .in_valid  (v[i-1]),
            .in_state  (state[i-1]),
            .subkey    (subkeys[i]),
            .out_valid (v[i]),
            .out_state (state[i])
        );
    end

    des_output_stage u_output_stage (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (v[ROUNDS]),
        .in_state   (state[ROUNDS]),
        .ciphertext (ciphertext),
        .ov         (ov)
    );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
    input  logic rst_req,
    output logic clock,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;

    logic por;

    // extra reset requests from the testbench are ored in
    assign rst = por | rst_req;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // power-on reset seen by three rising edges, released on a falling edge
    initial begin
        por = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        por = 1'b0;
    end

endmodule

//--- sim/des_tb.sv
module des_tb
    import des_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 10;
    localparam int N_KEYS         = 4;
    localparam int BLOCKS_PER_KEY = 8;
    localparam int STREAM_LEN     = 40;
    localparam int GAP_CYCLES     = 64;
    localparam int RESET_PRE      = 10;
    localparam int RESET_POST     = 12;
    localparam int TOTAL_BLOCKS   = 1 + N_KEYS * BLOCKS_PER_KEY + STREAM_LEN + RESET_PRE
                                    + RESET_POST;
    // kat, each key, stream, gaps and the reset test end with a drain
    localparam int N_DRAINS        = N_KEYS + 4;
    localparam int DRAIN_CYCLES    = PIPE_LATENCY + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS + GAP_CYCLES + N_DRAINS * DRAIN_CYCLES
                                     + 2 * PIPE_LATENCY + 20;

    localparam block_t KAT_KEY = 64'h133457799BBCDFF1;
    localparam block_t KAT_PT  = 64'h0123456789ABCDEF;
    localparam block_t KAT_CT  = 64'h85E813540F0AB405;

    logic   clock;
    logic   rst;
    logic   rst_req;
    logic   iv;
    logic   ov;
    block_t key;
    block_t plaintext;
    block_t ciphertext;

    int     seed;
    int     rnd;
    logic   checking;
    block_t popped;
    block_t expected_q [$];
    // iv as accepted at each of the last PIPE_LATENCY edges
    logic [PIPE_LATENCY-1:0] iv_hist;

    tb_clock_gen u_clock_gen (
        .rst_req (rst_req),
        .clock   (clock),
        .rst     (rst)
    );

    des u_des (
        .clock      (clock),
        .rst        (rst),
        .key        (key),
        .plaintext  (plaintext),
        .iv         (iv),
        .ciphertext (ciphertext),
        .ov         (ov)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // bit pos of value, counted from 1 at the msb of a width-bit field
    function automatic logic bit_of(logic [63:0] value, int width, int pos);
        return value[width - pos];
    endfunction

    function automatic block_t des_model(block_t key_in, block_t pt);
        cd_t         c_reg;
        cd_t         d_reg;
        logic [55:0] cd;
        subkey_t     k_round;
        subkey_t     mix;
        half_t       l_half;
        half_t       r_half;
        half_t       s_out;
        half_t       f_val;
        half_t       l_next;
        block_t      perm;
        block_t      pre;
        logic [5:0]  chunk;
        logic [1:0]  row;
        logic [3:0]  col;
        for (int i = 0; i < 56; i++) begin
            cd = {cd[54:0], bit_of(key_in, 64, PC1_TABLE[i])};
        end
        c_reg = cd[55:28];
        d_reg = cd[27:0];
        for (int i = 0; i < 64; i++) begin
            perm = {perm[62:0], bit_of(pt, 64, IP_TABLE[i])};
        end
        l_half = perm[63:32];
        r_half = perm[31:0];
        for (int r = 0; r < ROUNDS; r++) begin
            // one bit at a time, once or twice
            for (int n = 0; n < SHIFT_TABLE[r]; n++) begin
                c_reg = {c_reg[CD_W-2:0], c_reg[CD_W-1]};
                d_reg = {d_reg[CD_W-2:0], d_reg[CD_W-1]};
            end
            for (int i = 0; i < 48; i++) begin
                k_round = {k_round[46:0], bit_of(64'({c_reg, d_reg}), 56, PC2_TABLE[i])};
                mix     = {mix[46:0], bit_of(64'(r_half), 32, E_TABLE[i])};
            end
            mix = mix ^ k_round;
            for (int s = 0; s < 8; s++) begin
                chunk = mix[47 - 6 * s -: 6];
                row   = {chunk[5], chunk[0]};
                col   = chunk[4:1];
                s_out = {s_out[27:0], SBOX_TABLE[s][{row, col}]};
            end
            for (int i = 0; i < 32; i++) begin
                f_val = {f_val[30:0], bit_of(64'(s_out), 32, P_TABLE[i])};
            end
            l_next = r_half;
            r_half = l_half ^ f_val;
            l_half = l_next;
        end
        pre = {r_half, l_half};
        for (int i = 0; i < 64; i++) begin
            perm = {perm[62:0], bit_of(pre, 64, FP_TABLE[i])};
        end
        return perm;
    endfunction

    function automatic block_t random_block();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic load_key(input block_t k);
        @(negedge clock);
        iv  = 1'b0;
        key = k;
    endtask

    task automatic send_block(input block_t pt);
        @(negedge clock);
        iv        = 1'b1;
        plaintext = pt;
        expected_q.push_back(des_model(key, pt));
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        iv = 1'b0;
    endtask

    task automatic drain_pipeline();
        @(negedge clock);
        iv = 1'b0;
        while (expected_q.size() != 0) @(negedge clock);
    endtask

    // delay line of iv, cleared by every reset edge
    always @(posedge clock) begin
        if (rst) begin
            iv_hist  <= '0;
            checking <= 1'b1;
        end else begin
            iv_hist <= {iv_hist[PIPE_LATENCY-2:0], iv};
        end
    end

    // outputs are read at the rising edge, before the registers update
    always @(posedge clock) begin
        if (checking === 1'b1) begin
            assert (ov === iv_hist[PIPE_LATENCY-1]) else
                report_failure($sformatf("** Error at %0t: ov is %b, expected %b",
                                         $time, ov, iv_hist[PIPE_LATENCY-1]));
            if (ov === 1'b1) begin
                assert (expected_q.size() != 0) else
                    report_failure("ov went high while no block was left in the model queue");
                popped = expected_q.pop_front();
                assert (ciphertext === popped) else
                    report_failure($sformatf("** Error at %0t: ciphertext %h, expected %h",
                                             $time, ciphertext, popped));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        iv        = 1'b0;
        key       = '0;
        plaintext = '0;
        rst_req   = 1'b0;
        checking  = 1'b0;
        seed      = 33546;
        @(posedge clock);
        while (rst) @(posedge clock);

        // known answer against the constant, model checked on the side
        assert (des_model(KAT_KEY, KAT_PT) == KAT_CT) else
            report_failure($sformatf("** Error at %0t: model gives %h, expected %h",
                                     $time, des_model(KAT_KEY, KAT_PT), KAT_CT));
        load_key(KAT_KEY);
        send_block(KAT_PT);
        idle_cycle();
        while (ov !== 1'b1) @(negedge clock);
        assert (ciphertext === KAT_CT) else
            report_failure($sformatf("** Error at %0t: ciphertext %h, expected %h",
                                     $time, ciphertext, KAT_CT));
        drain_pipeline();

        // several keys, each one with its own burst
        for (int k = 0; k < N_KEYS; k++) begin
            load_key(random_block());
            repeat (BLOCKS_PER_KEY) send_block(random_block());
            drain_pipeline();
        end

        // back to back stream
        load_key(random_block());
        repeat (STREAM_LEN) send_block(random_block());
        drain_pipeline();

        // random gaps, the ov pattern is checked by the delay line
        load_key(random_block());
        repeat (GAP_CYCLES) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                send_block(random_block());
            end else begin
                idle_cycle();
            end
        end
        drain_pipeline();

        // reset while blocks are in flight
        load_key(random_block());
        repeat (RESET_PRE) send_block(random_block());
        @(negedge clock);
        iv      = 1'b0;
        rst_req = 1'b1;
        repeat (2) @(negedge clock);
        rst_req = 1'b0;
        expected_q.delete();
        repeat (PIPE_LATENCY) begin
            @(negedge clock);
            assert (ov === 1'b0) else
                report_failure($sformatf("** Error at %0t: ov is %b after reset, expected 0",
                                         $time, ov));
        end
        repeat (RESET_POST) send_block(random_block());
        drain_pipeline();

        repeat (2) @(negedge clock);
        if (expected_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure("blocks were still waiting in the model queue at the end");
        end
    end

endmodule

//--- vlog.f
verilog/des_pkg.sv
verilog/des_key_schedule.sv
verilog/des_feistel.sv
verilog/des_round.sv
verilog/des_input_stage.sv
verilog/des_output_stage.sv
verilog/des.sv
sim/tb_clock_gen.sv
sim/des_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DES testbench, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module des_tb -f vlog.f -o des_sim &&
./obj_dir/des_sim | grep "Finished with no errors" && exit 0 || exit 1
